//--- rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int XLEN  = 32;
  localparam int NREGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [15:0]     imm_t;

  // Instruction field positions
  localparam int OP_MSB  = 31;
  localparam int OP_LSB  = 26;
  localparam int RD_MSB  = 25;
  localparam int RD_LSB  = 21;
  localparam int RS_MSB  = 20;
  localparam int RS_LSB  = 16;
  localparam int RT_MSB  = 15;
  localparam int RT_LSB  = 11;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  localparam int ADDR_LSB = 2; // Word index starts above the byte offset

  // Code 0 and all unlisted codes run as a no-operation
  typedef enum logic [5:0] {
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_SLT  = 6'h05,
    OP_ADDI = 6'h06,
    OP_LW   = 6'h07,
    OP_SW   = 6'h08,
    OP_BEQ  = 6'h09,
    OP_HALT = 6'h3f
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    EX_RUN,
    EX_MEM_WAIT,
    EX_HALTED
  } exec_state_e;

  function automatic word_t sext_imm(imm_t imm);
    return {{(XLEN - 16){imm[15]}}, imm};
  endfunction

  // Branch offset counts words from the instruction after the BEQ
  function automatic word_t branch_target(word_t pc, imm_t imm);
    return pc + 32'd4 + (sext_imm(imm) << 2);
  endfunction

  // Register form, rd <= rs op rt
  function automatic word_t enc_r(opcode_e op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op, rd, rs, rt, 11'b0};
  endfunction

  // Immediate form; SW stores rd and BEQ compares rd with rs
  function automatic word_t enc_i(opcode_e op, reg_addr_t rd, reg_addr_t rs, imm_t imm);
    return {op, rd, rs, imm};
  endfunction

endpackage

//--- rtl/cpu_mem_if.sv
`timescale 1ns/1ps

interface cpu_mem_if;
  import cpu_pkg::*;

  word_t addr;        // Byte address
  logic  rd;
  logic  wr;
  word_t wr_data;
  word_t rd_data;     // Valid when rd is high and waitrequest low
  logic  waitrequest;

  modport master (
    output addr, rd, wr, wr_data,
    input  rd_data, waitrequest
  );

  modport slave (
    input  addr, rd, wr, wr_data,
    output rd_data, waitrequest
  );

endinterface

//--- rtl/rfile_if.sv
`timescale 1ns/1ps

interface rfile_if;
  import cpu_pkg::*;

  reg_addr_t rd_addr1;
  reg_addr_t rd_addr2;
  word_t     rd_data1;  // Combinational read data
  word_t     rd_data2;
  reg_addr_t wr_addr;
  logic      wr_enable;
  word_t     wr_data;

  modport core (
    output rd_addr1, rd_addr2, wr_addr, wr_enable, wr_data,
    input  rd_data1, rd_data2
  );

  modport rfile (
    input  rd_addr1, rd_addr2, wr_addr, wr_enable, wr_data,
    output rd_data1, rd_data2
  );

endinterface

//--- rtl/tcm.sv
`timescale 1ns/1ps

module tcm #(
  parameter int MEM_WORDS = 256
) (
  input  logic           clock,
  input  logic           reset,
  cpu_mem_if.slave       bus,
  input  logic           load_valid,
  output logic           load_ready,
  input  cpu_pkg::word_t load_addr,
  input  cpu_pkg::word_t load_data
);
  import cpu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  word_t             mem [MEM_WORDS];
  word_t             rd_q;
  logic              read_phase; // High in the second cycle of a read
  logic              load_en;    // Host port opens one cycle after reset
  logic [IDX_W-1:0]  core_idx;
  logic [IDX_W-1:0]  load_idx;

  assign core_idx = bus.addr[ADDR_LSB +: IDX_W];
  assign load_idx = load_addr[ADDR_LSB +: IDX_W];

  assign bus.waitrequest = bus.rd && !read_phase;
  assign bus.rd_data     = rd_q;

  // Host gets the RAM only in cycles the core leaves idle
  assign load_ready = load_en && !bus.rd && !bus.wr;

  always_ff @(posedge clock) begin
    if (reset) begin
      read_phase <= 1'b0;
      load_en    <= 1'b0;
    end else begin
      read_phase <= bus.rd && !read_phase;
      load_en    <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.wr) begin
      mem[core_idx] <= bus.wr_data;
    end else if (load_valid && load_ready) begin
      mem[load_idx] <= load_data;
    end
    if (bus.rd && !read_phase) begin
      rd_q <= mem[core_idx]; // Presented in the wait-free cycle
    end
  end

  a_rd_wr_excl: assert property (@(posedge clock) disable iff (reset)
    !(bus.rd && bus.wr));

  a_core_addr_range: assert property (@(posedge clock) disable iff (reset)
    (bus.rd || bus.wr) |-> (bus.addr >> ADDR_LSB) < MEM_WORDS);

  a_load_addr_range: assert property (@(posedge clock) disable iff (reset)
    (load_valid && load_ready) |-> (load_addr >> ADDR_LSB) < MEM_WORDS);

endmodule

//--- rtl/rfile.sv
`timescale 1ns/1ps

module rfile (
  input  logic  clock,
  input  logic  reset,
  rfile_if.rfile rf
);
  import cpu_pkg::*;

  word_t regs [1:NREGS-1]; // No storage behind r0

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr_enable && rf.wr_addr != '0) begin
      regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  // Reads see the old value during a write cycle
  always_comb begin
    if (rf.rd_addr1 == '0) begin
      rf.rd_data1 = '0;
    end else begin
      rf.rd_data1 = regs[rf.rd_addr1];
    end
  end

  always_comb begin
    if (rf.rd_addr2 == '0) begin
      rf.rd_data2 = '0;
    end else begin
      rf.rd_data2 = regs[rf.rd_addr2];
    end
  end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  logic lt_signed;

  assign lt_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b; // Also ADDI and load/store addresses
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_SLT: begin
        result = {{(XLEN - 1){1'b0}}, lt_signed};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- rtl/pipeline.sv
`timescale 1ns/1ps

module pipeline (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  cpu_mem_if.master          imem,
  cpu_mem_if.master          dmem,
  rfile_if.core              rf,
  output logic               retire_valid,
  output cpu_pkg::word_t     retire_pc,
  output cpu_pkg::reg_addr_t retire_rd,
  output cpu_pkg::word_t     retire_data,
  output logic               halted
);
  import cpu_pkg::*;

  word_t       pc;           // Address of the next fetch
  logic        run_q;
  logic        fetch_pend;   // Second cycle of an instruction read
  logic        fetch_start;
  logic        fetch_accept;
  logic        hold_valid;
  word_t       hold_instr;
  word_t       hold_pc;
  logic        hold_take;

  exec_state_e ex_state;
  logic        ex_valid;
  word_t       ex_instr;
  word_t       ex_pc;
  logic        ex_done;
  logic        ex_stop;
  logic        halt_now;
  logic        redirect;
  opcode_e     op;
  reg_addr_t   f_rd;
  reg_addr_t   f_rs;
  reg_addr_t   f_rt;
  imm_t        imm;
  logic        use_imm;
  alu_op_e     alu_op;
  word_t       alu_b;
  word_t       alu_result;
  reg_addr_t   wb_rd;
  word_t       wb_data;

  // Decode
  assign op   = opcode_e'(ex_instr[OP_MSB:OP_LSB]);
  assign f_rd = ex_instr[RD_MSB:RD_LSB];
  assign f_rs = ex_instr[RS_MSB:RS_LSB];
  assign f_rt = ex_instr[RT_MSB:RT_LSB];
  assign imm  = ex_instr[IMM_MSB:IMM_LSB];

  assign use_imm = (op == OP_ADDI) || (op == OP_LW) || (op == OP_SW);

  always_comb begin
    case (op)
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_SLT:  alu_op = ALU_SLT;
      default: alu_op = ALU_ADD;
    endcase
  end

  // SW and BEQ need rd as a source
  assign rf.rd_addr1 = f_rs;
  assign rf.rd_addr2 = (op == OP_SW || op == OP_BEQ) ? f_rd : f_rt;

  assign alu_b = use_imm ? sext_imm(imm) : rf.rd_data2;

  alu u_alu (
    .op     (alu_op),
    .a      (rf.rd_data1),
    .b      (alu_b),
    .result (alu_result)
  );

  assign dmem.addr    = alu_result;
  assign dmem.rd      = ex_valid && (op == OP_LW);
  assign dmem.wr      = ex_valid && (op == OP_SW);
  assign dmem.wr_data = rf.rd_data2;

  // A load finishes only once waitrequest drops
  always_comb begin
    case (ex_state)
      EX_RUN:      ex_done = ex_valid && !(dmem.rd && dmem.waitrequest);
      EX_MEM_WAIT: ex_done = !dmem.waitrequest;
      default:     ex_done = 1'b0;
    endcase
  end

  assign halt_now = ex_done && (op == OP_HALT);
  assign redirect = ex_done && (op == OP_BEQ) && (rf.rd_data1 == rf.rd_data2);
  assign ex_stop  = (ex_state == EX_HALTED) || halt_now;

  always_comb begin
    wb_rd   = '0;
    wb_data = '0;
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI: begin
        wb_rd   = f_rd;
        wb_data = alu_result;
      end
      OP_LW: begin
        wb_rd   = f_rd;
        wb_data = dmem.rd_data;
      end
      OP_SW: begin
        wb_data = rf.rd_data2; // Stored word shown on the trace
      end
      default: begin
      end
    endcase
  end

  // r0 destination makes the write a no-op in the register file
  assign rf.wr_enable = ex_done;
  assign rf.wr_addr   = wb_rd;
  assign rf.wr_data   = wb_data;

  // Fetch side
  assign hold_take    = hold_valid && (!ex_valid || ex_done) && !redirect && !ex_stop;
  assign fetch_accept = imem.rd && !imem.waitrequest;
  assign fetch_start  = run_q && !fetch_pend && !redirect && !ex_stop &&
                        (!hold_valid || hold_take);

  assign imem.addr    = pc;
  assign imem.rd      = fetch_pend || fetch_start;
  assign imem.wr      = 1'b0;
  assign imem.wr_data = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc         <= '0;
      run_q      <= 1'b0;
      fetch_pend <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      run_q      <= run;
      fetch_pend <= imem.rd && imem.waitrequest;
      if (redirect) begin
        pc <= branch_target(ex_pc, imm);
      end else if (fetch_accept) begin
        pc <= pc + 32'd4;
      end
      if (redirect) begin
        hold_valid <= 1'b0; // Drops the held word and any word landing now
      end else if (fetch_accept) begin
        hold_valid <= 1'b1;
      end else if (hold_take) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_accept) begin
      hold_instr <= imem.rd_data;
      hold_pc    <= pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_state     <= EX_RUN;
      ex_valid     <= 1'b0;
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      case (ex_state)
        EX_RUN: begin
          if (dmem.rd && dmem.waitrequest) begin
            ex_state <= EX_MEM_WAIT;
          end else if (halt_now) begin
            ex_state <= EX_HALTED;
          end
        end
        EX_MEM_WAIT: begin
          if (!dmem.waitrequest) begin
            ex_state <= EX_RUN;
          end
        end
        default: begin
          ex_state <= EX_HALTED; // Left only through reset
        end
      endcase
      if (hold_take) begin
        ex_valid <= 1'b1;
      end else if (ex_done) begin
        ex_valid <= 1'b0;
      end
      retire_valid <= ex_done;
      halted       <= (ex_state == EX_HALTED); // One cycle after HALT retires
    end
  end

  always_ff @(posedge clock) begin
    if (hold_take) begin
      ex_instr <= hold_instr;
      ex_pc    <= hold_pc;
    end
    if (ex_done) begin
      retire_pc   <= ex_pc;
      retire_rd   <= wb_rd;
      retire_data <= wb_data;
    end
  end

  a_imem_addr_hold: assert property (@(posedge clock) disable iff (reset)
    (imem.rd && imem.waitrequest) |=> (imem.rd && $stable(imem.addr)));

  a_dmem_addr_hold: assert property (@(posedge clock) disable iff (reset)
    (dmem.rd && dmem.waitrequest) |=> (dmem.rd && $stable(dmem.addr)));

  a_no_retire_halted: assert property (@(posedge clock) disable iff (reset)
    halted |-> !retire_valid);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  input  logic               imem_load_valid,
  output logic               imem_load_ready,
  input  cpu_pkg::word_t     imem_load_addr,
  input  cpu_pkg::word_t     imem_load_data,
  input  logic               dmem_load_valid,
  output logic               dmem_load_ready,
  input  cpu_pkg::word_t     dmem_load_addr,
  input  cpu_pkg::word_t     dmem_load_data,
  output logic               retire_valid,
  output cpu_pkg::word_t     retire_pc,
  output cpu_pkg::reg_addr_t retire_rd,
  output cpu_pkg::word_t     retire_data,
  output logic               halted
);

  cpu_mem_if imem_bus ();
  cpu_mem_if dmem_bus ();
  rfile_if   rf_bus ();

  pipeline u_pipeline (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .imem         (imem_bus.master),
    .dmem         (dmem_bus.master),
    .rf           (rf_bus.core),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  rfile u_rfile (
    .clock (clock),
    .reset (reset),
    .rf    (rf_bus.rfile)
  );

  // Instruction memory, the core only reads it
  tcm #(
    .MEM_WORDS (IMEM_WORDS)
  ) u_itcm (
    .clock      (clock),
    .reset      (reset),
    .bus        (imem_bus.slave),
    .load_valid (imem_load_valid),
    .load_ready (imem_load_ready),
    .load_addr  (imem_load_addr),
    .load_data  (imem_load_data)
  );

  tcm #(
    .MEM_WORDS (DMEM_WORDS)
  ) u_dtcm (
    .clock      (clock),
    .reset      (reset),
    .bus        (dmem_bus.slave),
    .load_valid (dmem_load_valid),
    .load_ready (dmem_load_ready),
    .load_addr  (dmem_load_addr),
    .load_data  (dmem_load_data)
  );

endmodule

//--- verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int NUM_ROWS     = 6;
  localparam int PROG_WORDS   = 8;
  localparam int DATA_WORDS   = 4;
  localparam int LOAD_TIMEOUT = 20;  // Cycles to wait for a load port
  localparam int RUN_TIMEOUT  = 500; // Cycles to wait for halted
  localparam int MODEL_STEPS  = 64;

  logic      clock;
  logic      reset;
  logic      run;
  logic      imem_load_valid;
  logic      imem_load_ready;
  word_t     imem_load_addr;
  word_t     imem_load_data;
  logic      dmem_load_valid;
  logic      dmem_load_ready;
  word_t     dmem_load_addr;
  word_t     dmem_load_data;
  logic      retire_valid;
  word_t     retire_pc;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      halted;

  // Stimulus table, one short program per row
  word_t prog_tab [NUM_ROWS][PROG_WORDS];
  word_t data_tab [NUM_ROWS][DATA_WORDS];
  bit    rand_tab [NUM_ROWS];   // Random ADDI immediates in this row

  word_t     prog [PROG_WORDS];
  word_t     dpre [DATA_WORDS];
  word_t     exp_pc [$];
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];
  integer    seed;

  cpu_top u_cpu_top (
    .clock           (clock),
    .reset           (reset),
    .run             (run),
    .imem_load_valid (imem_load_valid),
    .imem_load_ready (imem_load_ready),
    .imem_load_addr  (imem_load_addr),
    .imem_load_data  (imem_load_data),
    .dmem_load_valid (dmem_load_valid),
    .dmem_load_ready (dmem_load_ready),
    .dmem_load_addr  (dmem_load_addr),
    .dmem_load_data  (dmem_load_data),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd       (retire_rd),
    .retire_data     (retire_data),
    .halted          (halted)
  );

  always #10 clock = ~clock;

  task automatic check_equal(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s (got %h, expected %h)", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Errors found");
    $fatal(1, "wait expired");
  endtask

  task automatic build_table;
    word_t halt_w;
    halt_w = enc_i(OP_HALT, 0, 0, 16'h0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      rand_tab[r] = 1'b0;
      for (int i = 0; i < PROG_WORDS; i++) begin
        prog_tab[r][i] = halt_w;  // Unused slots halt
      end
      for (int i = 0; i < DATA_WORDS; i++) begin
        data_tab[r][i] = 32'h0101_0000 * (r + 1) + i * 4;
      end
    end
    // Register ops, negative immediate
    prog_tab[0][0] = enc_i(OP_ADDI, 1, 0, 16'd5);
    prog_tab[0][1] = enc_i(OP_ADDI, 2, 0, 16'hfffd);
    prog_tab[0][2] = enc_r(OP_ADD, 3, 1, 2);
    prog_tab[0][3] = enc_r(OP_SUB, 4, 2, 1);
    prog_tab[0][4] = enc_r(OP_AND, 5, 1, 4);
    prog_tab[0][5] = enc_r(OP_OR, 6, 1, 2);
    prog_tab[0][6] = enc_r(OP_SLT, 7, 2, 1);
    // r0 writes and unlisted opcodes
    prog_tab[1][0] = enc_i(OP_ADDI, 0, 0, 16'd7);
    prog_tab[1][1] = 32'h0000_0000;
    prog_tab[1][2] = enc_r(OP_ADD, 1, 0, 0);
    prog_tab[1][3] = enc_i(OP_ADDI, 2, 0, 16'd9);
    prog_tab[1][4] = enc_r(OP_SLT, 3, 2, 0);
    prog_tab[1][5] = {6'h20, 26'h3ff_ffff};
    prog_tab[1][6] = enc_r(OP_SUB, 4, 0, 2);
    // Seeded operands
    rand_tab[2]    = 1'b1;
    prog_tab[2][0] = enc_i(OP_ADDI, 1, 0, 16'h0);
    prog_tab[2][1] = enc_i(OP_ADDI, 2, 0, 16'h0);
    prog_tab[2][2] = enc_r(OP_ADD, 3, 1, 2);
    prog_tab[2][3] = enc_r(OP_SUB, 4, 1, 2);
    prog_tab[2][4] = enc_r(OP_SLT, 5, 1, 2);
    prog_tab[2][5] = enc_r(OP_SLT, 6, 2, 1);
    prog_tab[2][6] = enc_r(OP_AND, 7, 1, 2);
    // Loads, store then reload
    data_tab[3][0] = 32'h1234_5678;
    data_tab[3][1] = 32'hdead_beef;
    data_tab[3][2] = 32'd7;
    prog_tab[3][0] = enc_i(OP_LW, 1, 0, 16'd0);
    prog_tab[3][1] = enc_i(OP_LW, 2, 0, 16'd4);
    prog_tab[3][2] = enc_r(OP_ADD, 3, 1, 2);
    prog_tab[3][3] = enc_i(OP_SW, 3, 0, 16'd12);
    prog_tab[3][4] = enc_i(OP_LW, 4, 0, 16'd12);
    prog_tab[3][5] = enc_i(OP_LW, 5, 0, 16'd8);
    // Not-taken then taken branch
    prog_tab[4][0] = enc_i(OP_ADDI, 1, 0, 16'd1);
    prog_tab[4][1] = enc_i(OP_BEQ, 1, 0, 16'd1);
    prog_tab[4][2] = enc_i(OP_BEQ, 0, 0, 16'd1);
    prog_tab[4][3] = enc_i(OP_ADDI, 2, 0, 16'd99); // Skipped
    prog_tab[4][4] = enc_i(OP_ADDI, 3, 0, 16'd4);
    // Countdown loop with a backward branch
    prog_tab[5][0] = enc_i(OP_ADDI, 1, 0, 16'd3);
    prog_tab[5][1] = enc_i(OP_ADDI, 1, 1, 16'hffff);
    prog_tab[5][2] = enc_i(OP_BEQ, 1, 0, 16'd1);
    prog_tab[5][3] = enc_i(OP_BEQ, 0, 0, 16'hfffd);
  endtask

  // Steps the program by the instruction-set rules
  task automatic run_model;
    word_t     regs [32];
    word_t     dmem [256];
    word_t     pc;
    word_t     instr;
    word_t     simm;
    word_t     vs;
    word_t     vt;
    word_t     vd;
    word_t     res;
    logic [5:0] op;
    reg_addr_t rd;
    bit        done;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) dmem[i] = '0;
    for (int i = 0; i < DATA_WORDS; i++) dmem[i] = dpre[i];
    pc   = '0;
    done = 1'b0;
    for (int s = 0; s < MODEL_STEPS && !done; s++) begin
      if ((pc >> 2) >= PROG_WORDS) stop_on_timeout("model pc left the program");
      instr = prog[pc >> 2];
      op    = instr[31:26];
      rd    = instr[25:21];
      vs    = regs[instr[20:16]];
      vt    = regs[instr[15:11]];
      vd    = regs[rd];
      simm  = {{16{instr[15]}}, instr[15:0]};
      exp_pc.push_back(pc);
      pc = pc + 4;
      case (op)
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI, OP_LW: begin
          case (op)
            OP_ADD:  res = vs + vt;
            OP_SUB:  res = vs - vt;
            OP_AND:  res = vs & vt;
            OP_OR:   res = vs | vt;
            OP_SLT:  res = ($signed(vs) < $signed(vt)) ? 32'd1 : 32'd0;
            OP_ADDI: res = vs + simm;
            default: res = dmem[((vs + simm) >> 2) & 32'hff];
          endcase
          if (rd != 0) regs[rd] = res; // r0 stays zero
          exp_rd.push_back(rd);
          exp_data.push_back(res);
        end
        OP_SW: begin
          dmem[((vs + simm) >> 2) & 32'hff] = vd;
          exp_rd.push_back(0);
          exp_data.push_back(vd);
        end
        default: begin
          if (op == OP_BEQ && vs == vd) pc = pc + (simm << 2);
          if (op == OP_HALT) done = 1'b1;
          exp_rd.push_back(0);
          exp_data.push_back(0);
        end
      endcase
    end
    if (!done) stop_on_timeout("model found no HALT");
  endtask

  task automatic apply_reset;
    reset = 1'b1;
    run   = 1'b0;
    repeat (4) @(posedge clock);
    #2 reset = 1'b0;
    @(negedge clock);
    check_equal(imem_load_ready, 0, "imem ready in first cycle after reset");
    check_equal(dmem_load_ready, 0, "dmem ready in first cycle after reset");
    @(negedge clock);
    check_equal(imem_load_ready, 1, "imem ready before run");
    check_equal(dmem_load_ready, 1, "dmem ready before run");
    check_equal(retire_valid, 0, "retire_valid before run");
    check_equal(halted, 0, "halted before run");
    @(posedge clock);
    #2;
  endtask

  // Called 2 ns after a rising edge, returns at the same point
  task automatic load_word(input bit to_dmem, input word_t addr, input word_t data);
    bit got;
    imem_load_valid = !to_dmem;
    dmem_load_valid = to_dmem;
    imem_load_addr  = addr;
    dmem_load_addr  = addr;
    imem_load_data  = data;
    dmem_load_data  = data;
    got = 1'b0;
    for (int i = 0; i < LOAD_TIMEOUT && !got; i++) begin
      @(negedge clock);
      got = to_dmem ? dmem_load_ready : imem_load_ready;
    end
    if (!got) stop_on_timeout("load port never became ready");
    @(posedge clock);
    #2;
    imem_load_valid = 1'b0;
    dmem_load_valid = 1'b0;
  endtask

  task automatic run_row(input int r);
    int    n;
    bit    done;
    word_t rnd;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = prog_tab[r][i];
      if (rand_tab[r] && prog[i][31:26] == OP_ADDI) begin
        rnd           = $random(seed);
        prog[i][15:0] = rnd[15:0];
      end
    end
    for (int i = 0; i < DATA_WORDS; i++) dpre[i] = data_tab[r][i];
    apply_reset();
    for (int i = 0; i < PROG_WORDS; i++) load_word(1'b0, i * 4, prog[i]);
    for (int i = 0; i < DATA_WORDS; i++) load_word(1'b1, i * 4, dpre[i]);
    run_model();
    run  = 1'b1;
    n    = 0;
    done = 1'b0;
    for (int c = 0; c < RUN_TIMEOUT && !done; c++) begin
      @(negedge clock);
      if (retire_valid) begin
        check_equal(n < exp_pc.size(), 1, $sformatf("row %0d retired too many", r));
        check_equal(retire_pc, exp_pc[n], $sformatf("row %0d retire_pc #%0d", r, n));
        check_equal(retire_rd, exp_rd[n], $sformatf("row %0d retire_rd #%0d", r, n));
        check_equal(retire_data, exp_data[n], $sformatf("row %0d retire_data #%0d", r, n));
        n++;
      end
      if (halted) done = 1'b1;
    end
    if (!done) stop_on_timeout($sformatf("row %0d never raised halted", r));
    repeat (20) begin
      @(negedge clock);
      check_equal(retire_valid, 0, $sformatf("row %0d retire after halt", r));
      check_equal(halted, 1, $sformatf("row %0d halted dropped", r));
    end
    check_equal(n, exp_pc.size(), $sformatf("row %0d retired count", r));
    @(posedge clock);
    #2;
  endtask

  initial begin
    clock           = 1'b0;
    reset           = 1'b1;
    run             = 1'b0;
    imem_load_valid = 1'b0;
    imem_load_addr  = '0;
    imem_load_data  = '0;
    dmem_load_valid = 1'b0;
    dmem_load_addr  = '0;
    dmem_load_data  = '0;
    seed            = 32'h48bf_d977;
    build_table();
    @(posedge clock);
    #2;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("No errors");
    $finish;
  end

endmodule

//--- filelist.f
rtl/cpu_pkg.sv
rtl/cpu_mem_if.sv
rtl/rfile_if.sv
rtl/tcm.sv
rtl/rfile.sv
rtl/alu.sv
rtl/pipeline.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_subsystem

sources:
  - rtl/cpu_pkg.sv
  - rtl/cpu_mem_if.sv
  - rtl/rfile_if.sv
  - rtl/tcm.sv
  - rtl/rfile.sv
  - rtl/alu.sv
  - rtl/pipeline.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - verif/cpu_tb.sv
